// ==== hw/com_pad_tracker.sv ====
module com_pad_tracker (
  input  logic                                pipe_clk,
  input  logic                                rst,
  input  logic                                lnkup_n,
  input  logic [link_ctrl_pkg::ltssm_w-1:0]   ltssm_state,
  input  logic                                filter_active,
  input  logic                                com0,
  input  logic                                com1,
  input  logic                                pad0,
  input  logic                                pad1,
  output logic                                arm
);

  import link_ctrl_pkg::*;

  logic prev_com0;
  logic prev_com1;
  logic prev_pad1;
  logic used_q;
  logic arm_q;
  logic in_l0;
  logic seq_hit;

  assign in_l0 = (ltssm_state == ltssm_l0);

  // --------------------
  // sequence match
  // --------------------

  // a COM may sit in either byte, so the PADs that follow can straddle
  // the word boundary in two ways.
  assign seq_hit = (prev_com0 && prev_pad1 && pad0) ||
                   (prev_com1 && pad0 && pad1);

  always_ff @(posedge pipe_clk) begin
    if (rst || lnkup_n) begin
      prev_com0 <= 1'b0;
      prev_com1 <= 1'b0;
      prev_pad1 <= 1'b0;
      arm_q     <= 1'b0;
      used_q    <= 1'b0;
    end else begin
      prev_com0 <= com0;
      prev_com1 <= com1;
      prev_pad1 <= pad1;
      arm_q     <= seq_hit && !used_q;
      // once a filter has run, stay quiet until the link drops out of L0.
      used_q    <= in_l0 && (filter_active || used_q);
    end
  end

  assign arm = arm_q;

endmodule

// ==== hw/link_ctrl_pkg.sv ====
package link_ctrl_pkg;

  // --------------------
  // LTSSM and link status
  // --------------------

  localparam int ltssm_w = 6;
  localparam logic [ltssm_w-1:0] ltssm_l0 = 6'h20;

  localparam int width_w = 4;

  // sel_lnk_rate encoding.
  localparam logic rate_gen1 = 1'b0;
  localparam logic rate_gen2 = 1'b1;

  // --------------------
  // filter duration
  // --------------------

  localparam int filt_cnt_w = 16;

  // the filter is held for limit plus one cycles.
  localparam logic [filt_cnt_w-1:0] filt_len_gen1 = 16'd400;
  localparam logic [filt_cnt_w-1:0] filt_len_gen2 = 16'd800;
  localparam logic [filt_cnt_w-1:0] filt_len_fast = 16'd225;

endpackage

// ==== hw/pcie_upconfig_rx_top.sv ====
module pcie_upconfig_rx_top #(
  parameter bit         upstream_facing = 1'b0,
  parameter bit         fast_train      = 1'b0,
  parameter logic [5:0] link_cap_width  = 6'd8
) (
  input  logic                                pipe_clk,
  input  logic                                rst,
  input  logic                                phy_lnkup_n,
  input  logic [link_ctrl_pkg::ltssm_w-1:0]   ltssm_state,
  input  logic                                sel_lnk_rate,
  input  logic [1:0]                          directed_link_change,
  input  logic [link_ctrl_pkg::width_w-1:0]   negotiated_width,
  input  pipe_sym_pkg::pipe_rx_word_u         rx_data,
  input  logic [pipe_sym_pkg::pipe_bytes-1:0] rx_isk,
  output pipe_sym_pkg::pipe_rx_word_u         rx_data_out,
  output logic [pipe_sym_pkg::pipe_bytes-1:0] rx_isk_out,
  output logic                                filter_pipe
);

  logic com0;
  logic com1;
  logic pad0;
  logic pad1;
  logic arm;

  // --------------------
  // detect path
  // --------------------

  rx_symbol_decoder decoder_i (
    .pipe_clk (pipe_clk),
    .rst      (rst),
    .rx_data  (rx_data),
    .rx_isk   (rx_isk),
    .com0     (com0),
    .com1     (com1),
    .pad0     (pad0),
    .pad1     (pad1)
  );

  com_pad_tracker tracker_i (
    .pipe_clk      (pipe_clk),
    .rst           (rst),
    .lnkup_n       (phy_lnkup_n),
    .ltssm_state   (ltssm_state),
    .filter_active (filter_pipe),
    .com0          (com0),
    .com1          (com1),
    .pad0          (pad0),
    .pad1          (pad1),
    .arm           (arm)
  );

  upconfig_filter_ctrl #(
    .upstream_facing (upstream_facing),
    .fast_train      (fast_train),
    .link_cap_width  (link_cap_width)
  ) ctrl_i (
    .pipe_clk             (pipe_clk),
    .rst                  (rst),
    .lnkup_n              (phy_lnkup_n),
    .ltssm_state          (ltssm_state),
    .sel_lnk_rate         (sel_lnk_rate),
    .directed_link_change (directed_link_change),
    .negotiated_width     (negotiated_width),
    .arm                  (arm),
    .filter_active        (filter_pipe)
  );

  // --------------------
  // data path
  // --------------------

  pipe_rx_gate gate_i (
    .pipe_clk      (pipe_clk),
    .rst           (rst),
    .rx_data       (rx_data),
    .rx_isk        (rx_isk),
    .filter_active (filter_pipe),
    .rx_data_out   (rx_data_out),
    .rx_isk_out    (rx_isk_out)
  );

endmodule

// ==== hw/pipe_rx_gate.sv ====
module pipe_rx_gate (
  input  logic                                pipe_clk,
  input  logic                                rst,
  input  pipe_sym_pkg::pipe_rx_word_u         rx_data,
  input  logic [pipe_sym_pkg::pipe_bytes-1:0] rx_isk,
  input  logic                                filter_active,
  output pipe_sym_pkg::pipe_rx_word_u         rx_data_out,
  output logic [pipe_sym_pkg::pipe_bytes-1:0] rx_isk_out
);

  import pipe_sym_pkg::*;

  pipe_rx_word_u         data_q;
  logic [pipe_bytes-1:0] isk_q;

  // --------------------
  // output stage
  // --------------------

  // while filtering, the core is fed logical idle in place of the unwanted
  // training sets.
  always_ff @(posedge pipe_clk) begin
    if (rst || filter_active) begin
      data_q.raw <= idle_data;
      isk_q      <= '0;
    end else begin
      data_q.raw <= rx_data.raw;
      isk_q      <= rx_isk;
    end
  end

  assign rx_data_out = data_q;
  assign rx_isk_out  = isk_q;

endmodule

// ==== hw/pipe_sym_pkg.sv ====
package pipe_sym_pkg;

  // --------------------
  // PIPE word geometry
  // --------------------

  localparam int pipe_data_w = 16;
  localparam int pipe_bytes = 2;
  localparam int sym_w = pipe_data_w / pipe_bytes;

  // --------------------
  // symbol match masks
  // --------------------

  // every K-code candidate of interest has these bits set.
  localparam logic [sym_w-1:0] sym_k_mask = 8'hb4;

  // the remaining bits tell COM (K28.5) apart from PAD (K23.7).
  localparam logic [sym_w-1:0] com_low_mask = 8'h4b;
  localparam logic [sym_w-1:0] com_low_val = 8'h08;
  localparam logic [sym_w-1:0] pad_low_val = 8'h43;

  // logical idle as seen by the core above the PHY.
  localparam logic [pipe_data_w-1:0] idle_data = '0;

  // --------------------
  // receive word
  // --------------------

  // byte 0 of sym is the first symbol on the wire.
  typedef union packed {
    logic [pipe_data_w-1:0] raw;
    logic [pipe_bytes-1:0][sym_w-1:0] sym;
  } pipe_rx_word_u;

endpackage

// ==== hw/rx_symbol_decoder.sv ====
module rx_symbol_decoder (
  input  logic                                      pipe_clk,
  input  logic                                      rst,
  input  pipe_sym_pkg::pipe_rx_word_u               rx_data,
  input  logic [pipe_sym_pkg::pipe_bytes-1:0]        rx_isk,
  output logic                                      com0,
  output logic                                      com1,
  output logic                                      pad0,
  output logic                                      pad1
);

  import pipe_sym_pkg::*;

  logic [pipe_bytes-1:0] k_hit;
  logic [pipe_bytes-1:0] com_hit;
  logic [pipe_bytes-1:0] pad_hit;
  logic [pipe_bytes-1:0] com_q;
  logic [pipe_bytes-1:0] pad_q;

  // --------------------
  // per-byte compare
  // --------------------

  // only a K character can be COM or PAD, so the K flag gates both.
  always_comb begin
    for (int i = 0; i < pipe_bytes; i++) begin
      k_hit[i] = rx_isk[i] && ((rx_data.sym[i] & sym_k_mask) == sym_k_mask);
      com_hit[i] = k_hit[i] && ((rx_data.sym[i] & com_low_mask) == com_low_val);
      pad_hit[i] = k_hit[i] && ((rx_data.sym[i] & com_low_mask) == pad_low_val);
    end
  end

  // the register stage keeps the byte compare out of the sequence logic path.
  always_ff @(posedge pipe_clk) begin
    if (rst) begin
      com_q <= '0;
      pad_q <= '0;
    end else begin
      com_q <= com_hit;
      pad_q <= pad_hit;
    end
  end

  assign com0 = com_q[0];
  assign com1 = com_q[1];
  assign pad0 = pad_q[0];
  assign pad1 = pad_q[1];

endmodule

// ==== hw/upconfig_filter_ctrl.sv ====
module upconfig_filter_ctrl #(
  parameter bit         upstream_facing = 1'b0,
  parameter bit         fast_train      = 1'b0,
  parameter logic [5:0] link_cap_width  = 6'd8
) (
  input  logic                                pipe_clk,
  input  logic                                rst,
  input  logic                                lnkup_n,
  input  logic [link_ctrl_pkg::ltssm_w-1:0]   ltssm_state,
  input  logic                                sel_lnk_rate,
  input  logic [1:0]                          directed_link_change,
  input  logic [link_ctrl_pkg::width_w-1:0]   negotiated_width,
  input  logic                                arm,
  output logic                                filter_active
);

  import link_ctrl_pkg::*;

  logic [filt_cnt_w-1:0] cnt_q;
  logic [filt_cnt_w-1:0] filt_limit;
  logic [5:0]            neg_width_ext;
  logic                  filter_q;
  logic                  width_short;
  logic                  start_filter;

  // --------------------
  // start conditions
  // --------------------

  assign neg_width_ext = 6'(negotiated_width);
  assign width_short = (neg_width_ext != link_cap_width);

  // a width change this port directed itself must pass through untouched.
  assign start_filter = arm &&
                        (ltssm_state == ltssm_l0) &&
                        width_short &&
                        (directed_link_change == 2'b00);

  // --------------------
  // duration counter
  // --------------------

  always_comb begin
    if (fast_train) begin
      filt_limit = filt_len_fast;
    end else if (sel_lnk_rate == rate_gen2) begin
      filt_limit = filt_len_gen2;
    end else begin
      filt_limit = filt_len_gen1;
    end
  end

  // a fresh arm while filtering restarts the count from zero.
  always_ff @(posedge pipe_clk) begin
    if (rst || lnkup_n) begin
      cnt_q    <= '0;
      filter_q <= 1'b0;
    end else if (start_filter) begin
      cnt_q    <= '0;
      filter_q <= 1'b1;
    end else if (filter_q) begin
      if (cnt_q < filt_limit) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q    <= '0;
        filter_q <= 1'b0;
      end
    end
  end

  // an upstream port sees no unsolicited upconfigure, so it never filters.
  assign filter_active = upstream_facing ? 1'b0 : filter_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal in the run fails this script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_top \
  -f verilog.f \
  -Mdir obj_dir \
  -o tb_top_sim \
  && ./obj_dir/tb_top_sim \
  || {
    status=$?
    echo "build or simulation returned status ${status}"
    exit "${status}"
  }

// ==== testbench/tb_top.sv ====
module tb_top;

  import pipe_sym_pkg::*;
  import link_ctrl_pkg::*;

  // --------------------
  // constants
  // --------------------

  // the recovery state code takes the link out of L0.
  localparam logic [ltssm_w-1:0] ltssm_recovery = 6'h0c;
  localparam logic [7:0] sym_com = 8'hbc;
  localparam logic [7:0] sym_pad = 8'hf7;
  localparam int gen1_filter_len = 401;
  localparam int gen2_filter_len = 801;
  // the filter is first seen high at the second word after the completing word.
  localparam int rise_offset = 2;
  // three full gen1 windows, one gen2 window, and the short idle stretches.
  localparam int run_cycles = 3 * (gen1_filter_len + 20) + (gen2_filter_len + 20) + 300;
  localparam int watchdog_time = (run_cycles + 500) * 10;

  logic                 pipe_clk;
  logic                 rst;
  logic                 phy_lnkup_n;
  logic [ltssm_w-1:0]   ltssm_state;
  logic                 sel_lnk_rate;
  logic [1:0]           directed_link_change;
  logic [width_w-1:0]   negotiated_width;
  pipe_rx_word_u        rx_data;
  logic [1:0]           rx_isk;
  pipe_rx_word_u        rx_data_out;
  logic [1:0]           rx_isk_out;
  logic                 filter_pipe;

  integer seed;
  logic   exp_filt_prev;

  pcie_upconfig_rx_top #(
    .upstream_facing (1'b0),
    .fast_train      (1'b0),
    .link_cap_width  (6'd8)
  ) dut_i (
    .pipe_clk             (pipe_clk),
    .rst                  (rst),
    .phy_lnkup_n          (phy_lnkup_n),
    .ltssm_state          (ltssm_state),
    .sel_lnk_rate         (sel_lnk_rate),
    .directed_link_change (directed_link_change),
    .negotiated_width     (negotiated_width),
    .rx_data              (rx_data),
    .rx_isk               (rx_isk),
    .rx_data_out          (rx_data_out),
    .rx_isk_out           (rx_isk_out),
    .filter_pipe          (filter_pipe)
  );

  always #5 pipe_clk = ~pipe_clk;

  // --------------------
  // checking helpers
  // --------------------

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_outputs(input logic [15:0] word, input logic [1:0] isk,
                               input logic exp_filt);
    logic [15:0] exp_data;
    logic [1:0]  exp_isk;
    // the gate acts on the filter state seen at the edge that captured the word.
    exp_data = exp_filt_prev ? 16'h0000 : word;
    exp_isk  = exp_filt_prev ? 2'b00 : isk;
    assert (filter_pipe === exp_filt) else
      report_error($sformatf("filter_pipe is %b, expected %b", filter_pipe, exp_filt));
    assert (rx_data_out.raw === exp_data) else
      report_error($sformatf("rx_data_out is %h, expected %h", rx_data_out.raw, exp_data));
    assert (rx_isk_out === exp_isk) else
      report_error($sformatf("rx_isk_out is %b, expected %b", rx_isk_out, exp_isk));
    exp_filt_prev = exp_filt;
  endtask

  // called at a falling edge; checks the response one falling edge later.
  task automatic drive_word(input logic [15:0] word, input logic [1:0] isk,
                            input logic exp_filt);
    rx_data.raw = word;
    rx_isk      = isk;
    @(negedge pipe_clk);
    check_outputs(word, isk, exp_filt);
  endtask

  // data words with no K flags, so no COM can appear by accident.
  task automatic run_random(input int n, input int rise_at, input int high_len);
    logic [31:0] r;
    logic        exp_filt;
    for (int j = 1; j <= n; j++) begin
      r = $random(seed);
      exp_filt = (rise_at > 0) && (j >= rise_at) && (j < rise_at + high_len);
      drive_word(r[15:0], 2'b00, exp_filt);
    end
  endtask

  task automatic send_pattern(input bit com_in_byte1);
    logic [31:0] r;
    r = $random(seed);
    if (!com_in_byte1) begin
      drive_word({sym_pad, sym_com}, 2'b11, 1'b0);
      drive_word({r[7:0], sym_pad}, 2'b01, 1'b0);
    end else begin
      drive_word({sym_com, r[7:0]}, 2'b10, 1'b0);
      drive_word({sym_pad, sym_pad}, 2'b11, 1'b0);
    end
  endtask

  task automatic leave_l0(input int n);
    ltssm_state = ltssm_recovery;
    run_random(n, 0, 0);
    ltssm_state = ltssm_l0;
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic gen1_com_byte0();
    sel_lnk_rate = 1'b0;
    run_random(4, 0, 0);
    send_pattern(1'b0);
    run_random(gen1_filter_len + 20, rise_offset, gen1_filter_len);
  endtask

  task automatic gen2_com_byte1();
    leave_l0(3);
    sel_lnk_rate = 1'b1;
    send_pattern(1'b1);
    run_random(gen2_filter_len + 20, rise_offset, gen2_filter_len);
    sel_lnk_rate = 1'b0;
  endtask

  task automatic blocked_conditions();
    leave_l0(3);
    negotiated_width = 4'd8;
    send_pattern(1'b0);
    run_random(12, 0, 0);
    negotiated_width = 4'd4;
    directed_link_change = 2'b01;
    send_pattern(1'b1);
    run_random(12, 0, 0);
    directed_link_change = 2'b00;
    ltssm_state = ltssm_recovery;
    send_pattern(1'b0);
    run_random(12, 0, 0);
    ltssm_state = ltssm_l0;
  endtask

  task automatic once_per_l0_stay();
    send_pattern(1'b0);
    run_random(gen1_filter_len + 20, rise_offset, gen1_filter_len);
    // still in the same L0 stay, so this one is ignored.
    send_pattern(1'b0);
    run_random(12, 0, 0);
    leave_l0(3);
    send_pattern(1'b1);
    run_random(gen1_filter_len + 20, rise_offset, gen1_filter_len);
  endtask

  task automatic link_down_mid_filter();
    leave_l0(3);
    send_pattern(1'b0);
    run_random(100, rise_offset, gen1_filter_len);
    phy_lnkup_n = 1'b1;
    for (int i = 0; i < 8; i++) begin
      drive_word(16'h0000, 2'b00, 1'b0);
    end
    phy_lnkup_n = 1'b0;
    run_random(8, 0, 0);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    pipe_clk = 1'b0;
    seed = 47;
    exp_filt_prev = 1'b0;
    rst = 1'b1;
    phy_lnkup_n = 1'b0;
    ltssm_state = ltssm_l0;
    sel_lnk_rate = 1'b0;
    directed_link_change = 2'b00;
    negotiated_width = 4'd4;
    rx_data.raw = 16'h0000;
    rx_isk = 2'b00;
    repeat (5) @(posedge pipe_clk);
    @(negedge pipe_clk);
    rst = 1'b0;
    gen1_com_byte0();
    gen2_com_byte1();
    blocked_conditions();
    once_per_l0_stay();
    link_down_mid_filter();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("watchdog expired: the tests did not finish within %0d time units",
             watchdog_time);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== testbench/upconfig_props.sv ====
module upconfig_props (
  input logic                              pipe_clk,
  input logic                              rst,
  input logic                              lnkup_n,
  input logic [link_ctrl_pkg::ltssm_w-1:0] ltssm_state,
  input logic                              arm,
  input logic                              filter_active
);

  import link_ctrl_pkg::*;

  logic [filt_cnt_w-1:0] high_run;

  // number of edges filter_active has been sampled high without a break.
  always_ff @(posedge pipe_clk) begin
    if (rst || !filter_active) begin
      high_run <= '0;
    end else begin
      high_run <= high_run + filt_cnt_w'(1);
    end
  end

  // --------------------
  // properties
  // --------------------

  reset_clears_filter: assert property (
    @(posedge pipe_clk) (rst || lnkup_n) |=> !filter_active
  ) else $error("filter_active high after reset or with the link down");

  rise_needs_arm_in_l0: assert property (
    @(posedge pipe_clk) disable iff (rst)
    $rose(filter_active) |-> ($past(arm) && ($past(ltssm_state) == ltssm_l0))
  ) else $error("filter_active rose without an arm in L0");

  // the longest window is the gen2 limit plus one cycle.
  filter_length_bound: assert property (
    @(posedge pipe_clk) disable iff (rst)
    filter_active |-> (high_run <= filt_len_gen2)
  ) else $error("filter_active held longer than the gen2 window");

endmodule

bind upconfig_filter_ctrl upconfig_props props_i (
  .pipe_clk      (pipe_clk),
  .rst           (rst),
  .lnkup_n       (lnkup_n),
  .ltssm_state   (ltssm_state),
  .arm           (arm),
  .filter_active (filter_active)
);

// ==== verilog.f ====
hw/pipe_sym_pkg.sv
hw/link_ctrl_pkg.sv
hw/rx_symbol_decoder.sv
hw/com_pad_tracker.sv
hw/upconfig_filter_ctrl.sv
hw/pipe_rx_gate.sv
hw/pcie_upconfig_rx_top.sv
testbench/upconfig_props.sv
testbench/tb_top.sv
